// File: rfStackPkg.sv
// shared widths, register indices and APB address map for the banked register file
`default_nettype none

package rfStackPkg;

  // register file geometry
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned NumRegs      = 32;
  localparam int unsigned NumLevels    = 8;
  localparam int unsigned AddrWidth    = $clog2(NumRegs);
  localparam int unsigned LevelWidth   = $clog2(NumLevels);
  localparam int unsigned ApbAddrWidth = 8;

  typedef logic [DataWidth-1:0]    dataT;
  typedef logic [AddrWidth-1:0]    addrT;
  typedef logic [LevelWidth-1:0]   levelT;
  typedef logic [ApbAddrWidth-1:0] apbAddrT;

  // special registers
  localparam addrT  ZeroReg  = 5'd0;
  localparam addrT  RaReg    = 5'd1;
  localparam addrT  SpReg    = 5'd2;
  localparam dataT  RaMarker = '1;
  localparam levelT TopLevel = levelT'(NumLevels - 1);

  // host address map, register n at byte 4*n
  localparam apbAddrT RegWindowTop = 8'h7C;
  localparam apbAddrT LevelAddr    = 8'h80;
  localparam apbAddrT PushAddr     = 8'h84;
  localparam apbAddrT PopAddr      = 8'h88;

endpackage

`default_nettype wire

// File: rfPortIf.sv
// one write port plus one read port, used between the APB bridge and the banked register file
`timescale 1ns/10ps
`default_nettype none

interface rfPortIf
  import rfStackPkg::*;
();

  // write side, commits on the clock edge
  logic writeEn;
  addrT writeAddr;
  dataT writeData;

  // read side, data comes back in the same cycle
  addrT readAddr;
  dataT readData;

  modport requester (
    output writeEn, writeAddr, writeData, readAddr,
    input  readData
  );

  modport storage (
    input  writeEn, writeAddr, writeData, readAddr,
    output readData
  );

endinterface

`default_nettype wire

// File: registerFile.sv
// single bank of general registers, two combinational reads and one clocked write
`timescale 1ns/10ps
`default_nettype none

module registerFile
  import rfStackPkg::*;
#(
  parameter int unsigned Depth = NumRegs,
  parameter int unsigned Width = DataWidth
) (
  input  logic clk,
  input  logic rst,
  // read port A
  input  addrT raddrA,
  output dataT rdataA,
  // read port B
  input  addrT raddrB,
  output dataT rdataB,
  // write port
  input  addrT waddr,
  input  dataT wdata,
  input  logic we
);

  logic [Width-1:0] mem [Depth];

  // whole bank comes out of reset as zero
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < Depth; i++) begin
        mem[i] <= '0;
      end
    end else if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // async reads, one mux per reader
  assign rdataA = mem[raddrA];
  assign rdataB = mem[raddrB];

endmodule

`default_nettype wire

// File: levelCtrl.sv
// interrupt nesting depth, bounded push and pop with error reporting
`timescale 1ns/10ps
`default_nettype none

module levelCtrl
  import rfStackPkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  pushReq,
  input  logic  popReq,
  output levelT level,
  output logic  raMarkEn,
  output logic  levelErr
);

  logic atTop;
  logic atBottom;
  logic doPush;
  logic doPop;

  assign atTop    = (level == TopLevel);
  assign atBottom = (level == '0);

  // accepted requests only
  assign doPush = pushReq && !atTop;
  assign doPop  = popReq && !atBottom;

  // marker write rides along with the accepted push
  assign raMarkEn = doPush;

  // refused request flagged in the request cycle, level stays
  assign levelErr = (pushReq && atTop) || (popReq && atBottom);

  always_ff @(posedge clk) begin
    if (rst) begin
      level <= '0;
    end else if (doPush) begin
      level <= level + levelT'(1);
    end else if (doPop) begin
      level <= level - levelT'(1);
    end
  end

endmodule

`default_nettype wire

// File: apbRfBridge.sv
// APB slave turning host transfers into register accesses, level reads and push/pop pulses
`timescale 1ns/10ps
`default_nettype none

module apbRfBridge
  import rfStackPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  // APB slave
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apbAddrT   paddr,
  input  dataT      pwdata,
  output dataT      prdata,
  output logic      pready,
  output logic      pslverr,
  // register file write and first read port
  rfPortIf.requester rf,
  // level controller
  input  levelT     level,
  output logic      pushReq,
  output logic      popReq,
  input  logic      levelErr
);

  logic setup;
  logic access;
  logic aligned;
  logic regSelQ;
  logic levelSelQ;
  logic pushSelQ;
  logic popSelQ;
  logic mapErr;

  assign setup   = psel && !penable;
  assign access  = psel && penable;
  assign aligned = (paddr[1:0] == 2'b00);

  // decode in setup, paddr is stable into the access cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      regSelQ   <= 1'b0;
      levelSelQ <= 1'b0;
      pushSelQ  <= 1'b0;
      popSelQ   <= 1'b0;
    end else if (setup) begin
      regSelQ   <= aligned && (paddr <= RegWindowTop);
      levelSelQ <= (paddr == LevelAddr);
      pushSelQ  <= (paddr == PushAddr);
      popSelQ   <= (paddr == PopAddr);
    end
  end

  // nothing hit means unmapped or misaligned
  assign mapErr = !(regSelQ || levelSelQ || pushSelQ || popSelQ)
               || ((pushSelQ || popSelQ) && !pwrite)
               || (levelSelQ && pwrite);

  // register n at byte 4*n
  assign rf.writeAddr = paddr[6:2];
  assign rf.readAddr  = paddr[6:2];
  assign rf.writeData = pwdata;
  assign rf.writeEn   = access && pwrite && regSelQ;

  // single-cycle command pulses
  assign pushReq = access && pwrite && pushSelQ;
  assign popReq  = access && pwrite && popSelQ;

  // no wait states
  assign pready  = access;
  assign pslverr = access && (mapErr || levelErr);

  always_comb begin
    prdata = '0;
    if (access && !pwrite) begin
      if (regSelQ) prdata = rf.readData;
      else if (levelSelQ) prdata = dataT'(level);
    end
  end

endmodule

`default_nettype wire

// File: rfStack.sv
// level-banked register file with zero x0, shared sp in bank 0, ra marker on entry and bypass
`timescale 1ns/10ps
`default_nettype none

module rfStack
  import rfStackPkg::*;
(
  input  logic             clk,
  input  logic             rst,
  rfPortIf.storage         port,
  input  levelT            level,
  input  logic             raMarkEn,
  input  addrT             readAddr2,
  output dataT             readData2
);

  typedef dataT bankDataT [NumLevels];

  bankDataT rdA;
  bankDataT rdB;
  addrT     bankWaddr [NumLevels];
  dataT     bankWdata [NumLevels];
  logic     bankWe    [NumLevels];
  levelT    writeLevel;
  levelT    markLevel;

  // sp lives in bank 0 for every level
  assign writeLevel = (port.writeAddr == SpReg) ? '0 : level;
  // level changes on the same edge, so the marker goes to the bank being entered
  assign markLevel = level + levelT'(1);

  for (genvar k = 0; k < NumLevels; k++) begin : genBank
    always_comb begin
      bankWaddr[k] = port.writeAddr;
      bankWdata[k] = port.writeData;
      // x0 writes are dropped here
      bankWe[k] = port.writeEn && (port.writeAddr != ZeroReg) && (writeLevel == levelT'(k));
      if (raMarkEn && (markLevel == levelT'(k))) begin
        bankWaddr[k] = RaReg;
        bankWdata[k] = RaMarker;
        bankWe[k]    = 1'b1;
      end
    end

    registerFile bank (
      .clk    (clk),
      .rst    (rst),
      .raddrA (port.readAddr),
      .rdataA (rdA[k]),
      .raddrB (readAddr2),
      .rdataB (rdB[k]),
      .waddr  (bankWaddr[k]),
      .wdata  (bankWdata[k]),
      .we     (bankWe[k])
    );
  end

  // x0, then write-through, then sp, then own bank
  function automatic dataT pickRead(addrT addr, bankDataT banks, levelT lvl, logic wrEn,
                                    addrT wrAddr, dataT wrData);
    dataT value;
    if (addr == ZeroReg) value = '0;
    else if (wrEn && (addr == wrAddr)) value = wrData;
    else if (addr == SpReg) value = banks[0];
    else value = banks[lvl];
    return value;
  endfunction

  assign port.readData = pickRead(port.readAddr, rdA, level, port.writeEn,
                                  port.writeAddr, port.writeData);
  assign readData2 = pickRead(readAddr2, rdB, level, port.writeEn,
                              port.writeAddr, port.writeData);

endmodule

`default_nettype wire

// File: rfStackTop.sv
// top of the banked register file, host APB slave plus a core-side read port
`timescale 1ns/10ps
`default_nettype none

module rfStackTop
  import rfStackPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  // APB slave
  input  logic    psel,
  input  logic    penable,
  input  logic    pwrite,
  input  apbAddrT paddr,
  input  dataT    pwdata,
  output dataT    prdata,
  output logic    pready,
  output logic    pslverr,
  // core read port
  input  addrT    coreReadAddr,
  output dataT    coreReadData
);

  levelT level;
  logic  pushReq;
  logic  popReq;
  logic  levelErr;
  logic  raMarkEn;

  rfPortIf rfPort ();

  apbRfBridge bridge (
    .clk      (clk),
    .rst      (rst),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .rf       (rfPort.requester),
    .level    (level),
    .pushReq  (pushReq),
    .popReq   (popReq),
    .levelErr (levelErr)
  );

  levelCtrl levels (
    .clk      (clk),
    .rst      (rst),
    .pushReq  (pushReq),
    .popReq   (popReq),
    .level    (level),
    .raMarkEn (raMarkEn),
    .levelErr (levelErr)
  );

  rfStack regs (
    .clk       (clk),
    .rst       (rst),
    .port      (rfPort.storage),
    .level     (level),
    .raMarkEn  (raMarkEn),
    .readAddr2 (coreReadAddr),
    .readData2 (coreReadData)
  );

endmodule

`default_nettype wire

// File: tbRfStack.sv
// self-checking testbench for rfStackTop, drives APB transfers and watches the core read port
`timescale 1ns/10ps
`default_nettype none

module tbRfStack
  import rfStackPkg::*;
();

  localparam int ClkPeriod    = 4;
  localparam int ResetCycles  = 10;
  // APB transfers issued by all six tests
  localparam int NumTransfers = 79;
  localparam int TimeoutNs    = 2 * (NumTransfers * 2 * ClkPeriod + ResetCycles * ClkPeriod);
  localparam int CoreIdx      = 7;

  logic    clk = 1'b0;
  logic    rst;
  logic    psel;
  logic    penable;
  logic    pwrite;
  apbAddrT paddr;
  dataT    pwdata;
  dataT    prdata;
  logic    pready;
  logic    pslverr;
  addrT    coreReadAddr;
  dataT    coreReadData;

  string testName;
  int    errorCount = 0;
  int    checkCount = 0;
  int    testsPassed = 0;
  int    testsFailed = 0;
  int    errorsAtStart;
  int    expLevel;
  // core port as seen in the access cycle of the last transfer
  dataT  coreInAccess;

  rfStackTop DUT (
    .clk          (clk),
    .rst          (rst),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .coreReadAddr (coreReadAddr),
    .coreReadData (coreReadData)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  function automatic apbAddrT byteAddr(input int idx);
    return apbAddrT'(idx * 4);
  endfunction

  task automatic checkValue(input string what, input dataT expected, input dataT actual);
    checkCount++;
    assert (actual === expected) else begin
      $display("[ERROR] %s, %s: expected %h, actual %h", testName, what, expected, actual);
      errorCount++;
    end
  endtask

  // outside the access cycle the slave stays quiet
  task automatic checkQuiet();
    checkValue("pready in setup", '0, dataT'(pready));
    checkValue("pslverr in setup", '0, dataT'(pslverr));
    checkValue("prdata in setup", '0, prdata);
  endtask

  task automatic beginTest(input string name);
    testName = name;
    errorsAtStart = errorCount;
  endtask

  task automatic endTest();
    if (errorCount == errorsAtStart) begin
      testsPassed++;
      $display("test %s: pass", testName);
    end else begin
      testsFailed++;
      $display("test %s: FAIL", testName);
    end
  endtask

  // setup, access, then bus idle for one cycle
  task automatic apbWrite(input apbAddrT addr, input dataT data, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(negedge clk);
    checkQuiet();
    @(posedge clk);
    penable <= 1'b1;
    // sample mid-cycle once ready shows up
    @(negedge clk);
    while (pready !== 1'b1) @(negedge clk);
    err          = pslverr;
    coreInAccess = coreReadData;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apbRead(input apbAddrT addr, output dataT data, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(negedge clk);
    checkQuiet();
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    while (pready !== 1'b1) @(negedge clk);
    data = prdata;
    err  = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic writeReg(input apbAddrT addr, input dataT data, input logic expErr,
                          input string what);
    logic err;
    apbWrite(addr, data, err);
    checkValue({what, " pslverr"}, dataT'(expErr), dataT'(err));
  endtask

  // data only checked on transfers expected to succeed
  task automatic expectRead(input apbAddrT addr, input dataT expected, input logic expErr,
                            input string what);
    dataT data;
    logic err;
    apbRead(addr, data, err);
    checkValue({what, " pslverr"}, dataT'(expErr), dataT'(err));
    if (!expErr) checkValue(what, expected, data);
  endtask

  // write data on commands is don't care
  task automatic pushLevel();
    writeReg(PushAddr, $urandom, 1'b0, "push");
    expLevel++;
  endtask

  task automatic popLevel();
    writeReg(PopAddr, $urandom, 1'b0, "pop");
    expLevel--;
  endtask

  initial begin
    int   seedSink;
    dataT vals [4];
    dataT spVal;
    dataT a;
    dataT b;
    dataT c;
    seedSink = $urandom(32'h67cf);
    rst          <= 1'b1;
    psel         <= 1'b0;
    penable      <= 1'b0;
    pwrite       <= 1'b0;
    paddr        <= '0;
    pwdata       <= '0;
    coreReadAddr <= '0;
    expLevel = 0;
    repeat (ResetCycles) @(posedge clk);
    rst <= 1'b0;

    // x5 gets its own value at levels 0 to 3
    beginTest("bank isolation");
    for (int l = 0; l < 4; l++) begin
      vals[l] = $urandom;
      if (l > 0) pushLevel();
      expectRead(LevelAddr, dataT'(expLevel), 1'b0, "level after push");
      writeReg(byteAddr(5), vals[l], 1'b0, "write x5");
    end
    expectRead(byteAddr(5), vals[3], 1'b0, "x5 at level 3");
    for (int l = 2; l >= 0; l--) begin
      popLevel();
      expectRead(LevelAddr, dataT'(expLevel), 1'b0, "level after pop");
      expectRead(byteAddr(5), vals[l], 1'b0, "x5 after pop");
    end
    endTest();

    beginTest("x0 reads zero");
    @(posedge clk);
    coreReadAddr <= addrT'(0);
    writeReg(byteAddr(0), $urandom, 1'b0, "write x0");
    checkValue("core x0 during write", '0, coreInAccess);
    expectRead(byteAddr(0), '0, 1'b0, "apb x0");
    @(negedge clk);
    checkValue("core x0", '0, coreReadData);
    endTest();

    // one sp seen from every level
    beginTest("shared stack pointer");
    spVal = $urandom;
    pushLevel();
    // written from level 1, still has to land in bank 0
    writeReg(byteAddr(2), spVal, 1'b0, "write sp at level 1");
    expectRead(byteAddr(2), spVal, 1'b0, "sp at level 1");
    pushLevel();
    expectRead(byteAddr(2), spVal, 1'b0, "sp at level 2");
    popLevel();
    expectRead(byteAddr(2), spVal, 1'b0, "sp after pop");
    popLevel();
    expectRead(byteAddr(2), spVal, 1'b0, "sp back at level 0");
    endTest();

    beginTest("return marker and bounds");
    for (int l = 1; l < NumLevels; l++) begin
      pushLevel();
      expectRead(LevelAddr, dataT'(expLevel), 1'b0, "level after push");
      expectRead(byteAddr(1), '1, 1'b0, "ra marker");
    end
    writeReg(PushAddr, $urandom, 1'b1, "push at top");
    expectRead(LevelAddr, dataT'(NumLevels - 1), 1'b0, "level after refused push");
    for (int l = 1; l < NumLevels; l++) popLevel();
    writeReg(PopAddr, $urandom, 1'b1, "pop at level 0");
    expectRead(LevelAddr, '0, 1'b0, "level after refused pop");
    // level 0 is never entered by a push
    expectRead(byteAddr(1), '0, 1'b0, "ra at level 0");
    endTest();

    // same index, first at level 0 then at level 1
    beginTest("core port and bypass");
    a = $urandom;
    b = $urandom;
    c = $urandom;
    @(posedge clk);
    coreReadAddr <= addrT'(CoreIdx);
    writeReg(byteAddr(CoreIdx), a, 1'b0, "write a");
    checkValue("core bypass a", a, coreInAccess);
    @(negedge clk);
    checkValue("core after a", a, coreReadData);
    writeReg(byteAddr(CoreIdx), b, 1'b0, "write b");
    checkValue("core bypass b", b, coreInAccess);
    @(negedge clk);
    checkValue("core after b", b, coreReadData);
    pushLevel();
    @(negedge clk);
    checkValue("core at fresh level", '0, coreReadData);
    writeReg(byteAddr(CoreIdx), c, 1'b0, "write c");
    checkValue("core bypass c", c, coreInAccess);
    @(negedge clk);
    checkValue("core after c", c, coreReadData);
    popLevel();
    @(negedge clk);
    checkValue("core after pop", b, coreReadData);
    endTest();

    beginTest("address errors");
    expectRead(8'hC0, '0, 1'b1, "read unmapped");
    writeReg(8'hC0, $urandom, 1'b1, "write unmapped");
    // both alias x5 if the low bits were dropped
    expectRead(8'h15, '0, 1'b1, "read misaligned");
    writeReg(8'h16, $urandom, 1'b1, "write misaligned");
    expectRead(PushAddr, '0, 1'b1, "read push");
    expectRead(PopAddr, '0, 1'b1, "read pop");
    writeReg(LevelAddr, $urandom, 1'b1, "write level");
    expectRead(LevelAddr, '0, 1'b0, "level unchanged");
    expectRead(byteAddr(5), vals[0], 1'b0, "x5 unchanged");
    endTest();

    $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
             testsPassed, testsFailed, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // two cycles per transfer plus reset, twice over
  initial begin
    #(TimeoutNs);
    $display("timeout, tests still running after %0d ns", TimeoutNs);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: rfStack.f
rfStackPkg.sv
rfPortIf.sv
registerFile.sv
levelCtrl.sv
apbRfBridge.sv
rfStack.sv
rfStackTop.sv
tbRfStack.sv

// File: Bender.yml
package:
  name: rfStack

sources:
  - rfStackPkg.sv
  - rfPortIf.sv
  - registerFile.sv
  - levelCtrl.sv
  - apbRfBridge.sv
  - rfStack.sv
  - rfStackTop.sv
  - target: test
    files:
      - tbRfStack.sv
